/* source/board_pkg.sv */
`default_nettype none

package board_pkg;

    // Joystick word widths
    localparam int JOY_W       = 10;  // Game side
    localparam int BOARD_JOY_W = 16;  // As delivered by the board

    // Button positions in a board joystick word
    // Each one moves up by one when the game has three buttons
    localparam int START1_BASE = 6;
    localparam int START2_BASE = 7;
    localparam int COIN_BASE   = 8;
    localparam int PAUSE_BASE  = 9;

    // Status word bits still in use
    localparam int STATUS_FLIP_BIT = 12;  // Screen flip, a change resets the game
    localparam int STATUS_ROT_BIT  = 13;  // Rotate the direction controls

    // Levels decoded from the keyboard
    typedef struct packed {
        logic [JOY_W-1:0] key_joy1;
        logic [JOY_W-1:0] key_joy2;
        logic [1:0]       key_start;
        logic [1:0]       key_coin;
        logic             key_reset;
        logic             key_pause;
        logic             key_service;
        logic [3:0]       key_gfx;   // One per graphics layer
    } key_bus_t;

    // Controls as the game core sees them
    typedef struct packed {
        logic [JOY_W-1:0] joystick1;
        logic [JOY_W-1:0] joystick2;
        logic [1:0]       coin;
        logic [1:0]       start;
        logic             service;
    } game_inputs_t;

    // 8-bit video towards the display side
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic       hs;
        logic       vs;
        logic       de;  // High outside blanking
    } video_out_t;

endpackage

`default_nettype wire

/* source/game_reset.sv */
`default_nettype none

module game_reset #(
    parameter int RST_CNT_W = 8
) (
    input  logic clk_sys,
    input  logic rst,
    input  logic rst_req,
    input  logic downloading,
    input  logic soft_rst,
    input  logic dip_flip,
    output logic game_rst,
    output logic game_rst_n
);

    logic [RST_CNT_W-1:0] hold_cnt;
    logic                 last_flip;
    logic                 flip_change;
    logic                 trigger;
    logic                 pre_rst_n;

    assign flip_change = dip_flip != last_flip;

    // Any of these restarts the stretch
    assign trigger = rst | rst_req | downloading | soft_rst | flip_change;

    always_ff @(posedge clk_sys) begin
        last_flip <= dip_flip;
    end

    // Game reset stays high until the counter saturates
    always_ff @(posedge clk_sys) begin
        if (trigger) begin
            hold_cnt <= '0;
            game_rst <= 1'b1;
        end else if (hold_cnt != '1) begin
            hold_cnt <= hold_cnt + 1'b1;
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0;
        end
    end

    // Active-low copy, released two cycles after game_rst
    always_ff @(posedge clk_sys) begin
        if (rst || game_rst) begin
            pre_rst_n  <= 1'b0;
            game_rst_n <= 1'b0;
        end else begin
            pre_rst_n  <= 1'b1;
            game_rst_n <= pre_rst_n;
        end
    end

endmodule

`default_nettype wire

/* source/input_map.sv */
`default_nettype none

module input_map #(
    parameter int unsigned THREE_BUTTONS     = 0,
    parameter bit          INPUTS_ACTIVE_LOW = 1'b1
) (
    input  logic                            clk_sys,
    input  logic                            rst,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joystick1,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joystick2,
    input  board_pkg::key_bus_t             keys,
    input  logic                            rot_control,
    output board_pkg::game_inputs_t         game_in,
    output logic                            joy_pause
);

    import board_pkg::*;

    localparam int START1_BIT = START1_BASE + THREE_BUTTONS;
    localparam int START2_BIT = START2_BASE + THREE_BUTTONS;
    localparam int COIN_BIT   = COIN_BASE + THREE_BUTTONS;
    localparam int PAUSE_BIT  = PAUSE_BASE + THREE_BUTTONS;

    // Idle value, doubles as the inversion mask
    localparam game_inputs_t INACTIVE = {$bits(game_inputs_t){INPUTS_ACTIVE_LOW}};

    logic [BOARD_JOY_W-1:0] joy1_sync;
    logic [BOARD_JOY_W-1:0] joy2_sync;
    game_inputs_t           merged;

    // Swaps the direction bits for rotated cabinets
    function automatic logic [JOY_W-1:0] rotate_dirs(
        input logic [JOY_W-1:0] joy,
        input logic             rot
    );
        rotate_dirs = joy;
        if (rot) begin
            rotate_dirs[3:0] = {joy[0], joy[1], joy[3], joy[2]};
        end
    endfunction

    // Board joysticks come from another domain
    always_ff @(posedge clk_sys) begin
        joy1_sync <= board_joystick1;
        joy2_sync <= board_joystick2;
    end

    assign joy_pause = joy1_sync[PAUSE_BIT] | joy2_sync[PAUSE_BIT];

    always_comb begin
        merged.joystick1 = rotate_dirs(joy1_sync[JOY_W-1:0] | keys.key_joy1, rot_control);
        merged.joystick2 = rotate_dirs(joy2_sync[JOY_W-1:0] | keys.key_joy2, rot_control);

        // Each player has a coin slot
        merged.coin = {joy2_sync[COIN_BIT], joy1_sync[COIN_BIT]} | keys.key_coin;

        // Either joystick may start either player
        merged.start = {joy1_sync[START2_BIT], joy1_sync[START1_BIT]}
                     | {joy2_sync[START2_BIT], joy2_sync[START1_BIT]}
                     | keys.key_start;

        merged.service = keys.key_service;  // Keyboard only
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_in <= INACTIVE;
        end else begin
            game_in <= merged ^ INACTIVE;  // Polarity as the core expects
        end
    end

endmodule

`default_nettype wire

/* source/ctrl_toggles.sv */
`default_nettype none

module ctrl_toggles (
    input  logic                clk_sys,
    input  logic                rst,
    input  board_pkg::key_bus_t keys,
    input  logic                joy_pause,
    output logic                game_pause,
    output logic [3:0]          gfx_en,
    output logic                soft_rst
);

    logic       last_key_pause;
    logic       last_joy_pause;
    logic       last_key_reset;
    logic [3:0] last_gfx;
    logic       pause_hit;
    logic [3:0] gfx_hit;

    // Previous samples for edge detection
    always_ff @(posedge clk_sys) begin
        last_key_pause <= keys.key_pause;
        last_joy_pause <= joy_pause;
        last_key_reset <= keys.key_reset;
        last_gfx       <= keys.key_gfx;
    end

    // Either source may toggle pause
    assign pause_hit = (keys.key_pause & ~last_key_pause) | (joy_pause & ~last_joy_pause);

    assign gfx_hit = keys.key_gfx & ~last_gfx;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_pause <= 1'b0;
            gfx_en     <= 4'hf;  // All layers on
            soft_rst   <= 1'b0;
        end else begin
            // Single pulse per key press
            soft_rst <= keys.key_reset & ~last_key_reset;

            if (pause_hit) begin
                game_pause <= ~game_pause;
            end

            gfx_en <= gfx_en ^ gfx_hit;  // Each layer flips on its own key
        end
    end

endmodule

`default_nettype wire

/* source/color_expand.sv */
`default_nettype none

module color_expand #(
    parameter int COLORW = 4
) (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  logic [COLORW-1:0]     game_r,
    input  logic [COLORW-1:0]     game_g,
    input  logic [COLORW-1:0]     game_b,
    input  logic                  LHBL,
    input  logic                  LVBL,
    input  logic                  hs,
    input  logic                  vs,
    output board_pkg::video_out_t video
);

    logic [7:0] r_q;
    logic [7:0] g_q;
    logic [7:0] b_q;
    logic       hs_q;
    logic       vs_q;
    logic       de_q;

    // Repeats the channel from its MSB down until 8 bits are filled
    function automatic logic [7:0] extend8(input logic [COLORW-1:0] c);
        for (int i = 0; i < 8; i++) begin
            extend8[7-i] = c[COLORW-1-(i % COLORW)];
        end
    endfunction

    always_ff @(posedge clk_sys) begin
        r_q <= extend8(game_r);
        g_q <= extend8(game_g);
        b_q <= extend8(game_b);
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            hs_q <= 1'b0;
            vs_q <= 1'b0;
            de_q <= 1'b0;
        end else begin
            hs_q <= hs;
            vs_q <= vs;
            de_q <= LHBL & LVBL;  // Blanking signals are active low
        end
    end

    always_comb begin
        video.r  = r_q;
        video.g  = g_q;
        video.b  = b_q;
        video.hs = hs_q;
        video.vs = vs_q;
        video.de = de_q;
    end

endmodule

`default_nettype wire

/* source/board_top.sv */
`default_nettype none

module board_top #(
    parameter int unsigned THREE_BUTTONS     = 0,
    parameter bit          INPUTS_ACTIVE_LOW = 1'b1,
    parameter int          COLORW            = 4,
    parameter int          RST_CNT_W         = 8
) (
    input  logic                              clk_sys,
    input  logic                              rst,
    input  logic                              rst_req,
    input  logic                              downloading,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joystick1,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joystick2,
    input  board_pkg::key_bus_t               keys,
    input  logic [31:0]                       status,
    input  logic [COLORW-1:0]                 game_r,
    input  logic [COLORW-1:0]                 game_g,
    input  logic [COLORW-1:0]                 game_b,
    input  logic                              LHBL,
    input  logic                              LVBL,
    input  logic                              hs,
    input  logic                              vs,
    output board_pkg::game_inputs_t           game_in,
    output logic                              game_pause,
    output logic [3:0]                        gfx_en,
    output logic                              game_rst,
    output logic                              game_rst_n,
    output board_pkg::video_out_t             video
);

    import board_pkg::*;

    logic dip_flip;
    logic rot_control;
    logic joy_pause;   // Pause request from either joystick
    logic soft_rst;

    assign dip_flip    = status[STATUS_FLIP_BIT];
    assign rot_control = status[STATUS_ROT_BIT];

    game_reset #(
        .RST_CNT_W (RST_CNT_W)
    ) i_game_reset (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .rst_req     (rst_req),
        .downloading (downloading),
        .soft_rst    (soft_rst),
        .dip_flip    (dip_flip),
        .game_rst    (game_rst),
        .game_rst_n  (game_rst_n)
    );

    input_map #(
        .THREE_BUTTONS     (THREE_BUTTONS),
        .INPUTS_ACTIVE_LOW (INPUTS_ACTIVE_LOW)
    ) i_input_map (
        .clk_sys         (clk_sys),
        .rst             (rst),
        .board_joystick1 (board_joystick1),
        .board_joystick2 (board_joystick2),
        .keys            (keys),
        .rot_control     (rot_control),
        .game_in         (game_in),
        .joy_pause       (joy_pause)
    );

    ctrl_toggles i_ctrl_toggles (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .keys       (keys),
        .joy_pause  (joy_pause),
        .game_pause (game_pause),
        .gfx_en     (gfx_en),
        .soft_rst   (soft_rst)
    );

    color_expand #(
        .COLORW (COLORW)
    ) i_color_expand (
        .clk_sys (clk_sys),
        .rst     (rst),
        .game_r  (game_r),
        .game_g  (game_g),
        .game_b  (game_b),
        .LHBL    (LHBL),
        .LVBL    (LVBL),
        .hs      (hs),
        .vs      (vs),
        .video   (video)
    );

endmodule

`default_nettype wire

/* bench/board_tb.sv */
`default_nettype none

module board_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import board_pkg::*;

    localparam int          THREE_BUTTONS = 1;
    localparam bit          ACTIVE_LOW    = 1'b1;
    localparam int          COLORW        = 4;
    localparam int          RST_CNT_W     = 4;
    localparam int          CLK_PERIOD    = 20;
    localparam int          RESET_CYCLES  = 8;
    localparam int unsigned SEED          = 32'h6851;
    localparam int          NUM_TESTS     = 5;
    localparam int          STRETCH       = 2 ** RST_CNT_W;  // Edges from last trigger to release
    localparam int          STRETCH_LEN   = STRETCH + 8;
    localparam int          MAP_VECTORS   = 200;
    localparam int          MAP_HOLD      = 3;
    localparam int          VID_VECTORS   = 100;
    localparam int          WATCHDOG_CYCLES = RESET_CYCLES + 4 * (STRETCH_LEN + 8) + 40
                                            + MAP_VECTORS * MAP_HOLD + VID_VECTORS + 200;

    // Button positions for a three-button game
    localparam int START1_BIT = START1_BASE + THREE_BUTTONS;
    localparam int START2_BIT = START2_BASE + THREE_BUTTONS;
    localparam int COIN_BIT   = COIN_BASE + THREE_BUTTONS;
    localparam int PAUSE_BIT  = PAUSE_BASE + THREE_BUTTONS;

    logic                   clk_sys;
    logic                   rst;
    logic                   rst_req;
    logic                   downloading;
    logic [BOARD_JOY_W-1:0] board_joystick1;
    logic [BOARD_JOY_W-1:0] board_joystick2;
    key_bus_t               keys;
    logic [31:0]            status;
    logic [COLORW-1:0]      game_r, game_g, game_b;
    logic                   LHBL, LVBL, hs, vs;
    game_inputs_t           game_in;
    logic                   game_pause;
    logic [3:0]             gfx_en;
    logic                   game_rst, game_rst_n;
    video_out_t             video;

    logic                   map_check;  // Compare enables
    logic                   vid_check;
    video_out_t             vid_expect;
    game_inputs_t           map_expect;
    int                     errors;
    int                     checks;
    int                     tests_failed;
    int                     test_errors;  // Error count when the current test began
    int unsigned            seed_state;

    board_top #(
        .THREE_BUTTONS     (THREE_BUTTONS),
        .INPUTS_ACTIVE_LOW (ACTIVE_LOW),
        .COLORW            (COLORW),
        .RST_CNT_W         (RST_CNT_W)
    ) i_dut (.*);

    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    // Channel repeated until at least 8 bits, then the top 8 kept
    function automatic logic [7:0] widen(input logic [COLORW-1:0] c);
        logic [15:0] acc;
        int          filled;
        acc    = '0;
        filled = 0;
        while (filled < 8) begin
            acc    = (acc << COLORW) | 16'(c);
            filled = filled + COLORW;
        end
        return 8'(acc >> (filled - 8));
    endfunction

    function automatic video_out_t expected_video(
        input logic [COLORW-1:0] r,
        input logic [COLORW-1:0] g,
        input logic [COLORW-1:0] b,
        input logic              hblank_n,
        input logic              vblank_n,
        input logic              hsync,
        input logic              vsync
    );
        video_out_t v;
        v.r  = widen(r);
        v.g  = widen(g);
        v.b  = widen(b);
        v.hs = hsync;
        v.vs = vsync;
        v.de = hblank_n & vblank_n;
        return v;
    endfunction

    function automatic game_inputs_t expected_inputs(
        input logic [BOARD_JOY_W-1:0] j1,
        input logic [BOARD_JOY_W-1:0] j2,
        input key_bus_t               k,
        input logic                   rot
    );
        game_inputs_t     res;
        logic [JOY_W-1:0] d1;
        logic [JOY_W-1:0] d2;
        d1            = j1[JOY_W-1:0] | k.key_joy1;
        d2            = j2[JOY_W-1:0] | k.key_joy2;
        res.joystick1 = d1;
        res.joystick2 = d2;
        if (rot) begin
            res.joystick1[3] = d1[0];
            res.joystick1[2] = d1[1];
            res.joystick1[1] = d1[3];
            res.joystick1[0] = d1[2];
            res.joystick2[3] = d2[0];
            res.joystick2[2] = d2[1];
            res.joystick2[1] = d2[3];
            res.joystick2[0] = d2[2];
        end
        res.coin[0]  = j1[COIN_BIT] | k.key_coin[0];
        res.coin[1]  = j2[COIN_BIT] | k.key_coin[1];
        res.start[0] = j1[START1_BIT] | j2[START1_BIT] | k.key_start[0];
        res.start[1] = j1[START2_BIT] | j2[START2_BIT] | k.key_start[1];
        res.service  = k.key_service;
        if (ACTIVE_LOW) begin
            res = ~res;
        end
        return res;
    endfunction

    // Colour reference follows the DUT register by one edge
    always @(posedge clk_sys) begin
        vid_expect <= expected_video(game_r, game_g, game_b, LHBL, LVBL, hs, vs);
    end

    always @(negedge clk_sys) begin
        if (map_check) begin
            map_expect = expected_inputs(board_joystick1, board_joystick2, keys,
                                         status[STATUS_ROT_BIT]);
            checks++;
            assert (game_in === map_expect) else begin
                errors++;
                $display("Mismatch at %0t ns: game_in %h, expected %h", $time, game_in, map_expect);
            end
        end
        if (vid_check) begin
            checks++;
            assert (video === vid_expect) else begin
                errors++;
                $display("Mismatch at %0t ns: video %h, expected %h", $time, video, vid_expect);
            end
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            $display("Test %s passed", name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    // Starts right after the last edge that samples a trigger
    task automatic measure_stretch(input string what);
        int fall_at;
        int rise_at;
        fall_at = 0;
        rise_at = 0;
        @(negedge clk_sys);
        check_value({what, " game_rst after trigger"}, game_rst, 1);
        for (int k = 1; k <= STRETCH_LEN && rise_at == 0; k++) begin
            @(posedge clk_sys);
            @(negedge clk_sys);
            if (fall_at == 0 && !game_rst) begin
                fall_at = k;
            end
            if (fall_at != 0 && rise_at == 0 && game_rst_n) begin
                rise_at = k;
            end
        end
        check_value({what, " fall edge"}, fall_at, STRETCH);
        check_value({what, " release edge"}, rise_at, STRETCH + 2);
    endtask

    initial begin
        logic [3:0] gfx_model;
        clk_sys         = 1'b0;
        rst             = 1'b1;
        rst_req         = 1'b0;
        downloading     = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        keys            = '0;
        status          = '0;
        game_r          = '0;
        game_g          = '0;
        game_b          = '0;
        LHBL            = 1'b0;
        LVBL            = 1'b0;
        hs              = 1'b0;
        vs              = 1'b0;
        map_check       = 1'b0;
        vid_check       = 1'b0;
        errors          = 0;
        checks          = 0;
        tests_failed    = 0;
        test_errors     = 0;
        seed_state      = $urandom(SEED);

        // Reset stretch after rst, rst_req and a flip change
        repeat (RESET_CYCLES - 1) begin
            @(posedge clk_sys);
            @(negedge clk_sys);
            check_value("game_in during reset", game_in,
                        expected_inputs('0, '0, '0, 1'b0));
        end
        @(posedge clk_sys);
        rst <= 1'b0;
        measure_stretch("rst");
        @(posedge clk_sys);
        rst_req <= 1'b1;
        @(posedge clk_sys);
        rst_req <= 1'b0;
        measure_stretch("rst_req");
        @(posedge clk_sys);
        status[STATUS_FLIP_BIT] <= ~status[STATUS_FLIP_BIT];
        @(posedge clk_sys);
        measure_stretch("flip");
        end_test("reset_stretch");

        @(posedge clk_sys);
        keys.key_reset <= 1'b1;
        repeat (2) @(posedge clk_sys);  // Pulse reaches the counter on the second edge
        measure_stretch("soft reset");
        repeat (4) begin
            @(posedge clk_sys);
            @(negedge clk_sys);
            check_value("game_rst with key_reset held", game_rst, 0);
        end
        @(posedge clk_sys);
        keys.key_reset <= 1'b0;
        end_test("soft_reset");

        @(negedge clk_sys);
        gfx_model = 4'hf;
        check_value("gfx_en after reset", gfx_en, gfx_model);
        check_value("game_pause after reset", game_pause, 0);
        for (int i = 0; i < 4; i++) begin
            @(posedge clk_sys);
            keys.key_gfx <= 4'b0001 << i;
            @(posedge clk_sys);
            keys.key_gfx <= '0;
            @(negedge clk_sys);
            gfx_model[i] = ~gfx_model[i];
            check_value("gfx_en after layer key", gfx_en, gfx_model);
        end
        @(posedge clk_sys);
        keys.key_pause <= 1'b1;
        @(posedge clk_sys);
        keys.key_pause <= 1'b0;
        @(negedge clk_sys);
        check_value("game_pause after pause key", game_pause, 1);
        @(posedge clk_sys);
        board_joystick2[PAUSE_BIT] <= 1'b1;
        @(posedge clk_sys);
        board_joystick2[PAUSE_BIT] <= 1'b0;
        repeat (4) @(posedge clk_sys);  // Must flip once only
        @(negedge clk_sys);
        check_value("game_pause after joystick pause", game_pause, 0);
        end_test("toggles");

        for (int n = 0; n < MAP_VECTORS; n++) begin
            @(posedge clk_sys);
            map_check              <= 1'b0;
            board_joystick1        <= BOARD_JOY_W'($urandom);
            board_joystick2        <= BOARD_JOY_W'($urandom);
            keys.key_joy1          <= JOY_W'($urandom);
            keys.key_joy2          <= JOY_W'($urandom);
            keys.key_start         <= 2'($urandom);
            keys.key_coin          <= 2'($urandom);
            keys.key_service       <= 1'($urandom);
            status[STATUS_ROT_BIT] <= 1'($urandom);
            repeat (MAP_HOLD - 1) @(posedge clk_sys);
            map_check <= 1'b1;  // Joysticks settle after two edges
        end
        @(posedge clk_sys);
        map_check <= 1'b0;
        end_test("joystick_mapping");

        for (int n = 0; n < VID_VECTORS; n++) begin
            @(posedge clk_sys);
            vid_check <= 1'b1;
            game_r    <= COLORW'($urandom);
            game_g    <= COLORW'($urandom);
            game_b    <= COLORW'($urandom);
            LHBL      <= 1'($urandom);
            LVBL      <= 1'($urandom);
            hs        <= 1'($urandom);
            vs        <= 1'($urandom);
        end
        repeat (2) @(posedge clk_sys);
        vid_check <= 1'b0;
        end_test("colour_expansion");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 NUM_TESTS, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
source/board_pkg.sv
source/game_reset.sv
source/input_map.sv
source/ctrl_toggles.sv
source/color_expand.sv
source/board_top.sv
bench/board_tb.sv

/* Bender.yml */
package:
  name: board_glue

sources:
  - source/board_pkg.sv
  - source/game_reset.sv
  - source/input_map.sv
  - source/ctrl_toggles.sv
  - source/color_expand.sv
  - source/board_top.sv
  - target: test
    files:
      - bench/board_tb.sv
